// ==== axi4l_chan_slice.sv ====
`timescale 1ns/1ps

module axi4l_chan_slice #(
    parameter axi4l_pkg::slice_mode_t SLICE_MODE = axi4l_pkg::SLICE_FULL,
    parameter int WIDTH = 32
) (
    input  logic             aclk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    if (SLICE_MODE == axi4l_pkg::SLICE_BYPASS) begin : g_bypass
        assign in_ready  = out_ready;
        assign out_valid = in_valid;
        assign out_data  = in_data;
    end else if (SLICE_MODE == axi4l_pkg::SLICE_LIGHT) begin : g_light
        logic             full_q;
        logic             ready_q;
        logic [WIDTH-1:0] data_q;
        logic             in_fire;

        assign in_fire = in_valid && ready_q;  // ready only while empty

        always_ff @(posedge aclk) begin
            if (rst) begin
                full_q  <= 1'b0;
                ready_q <= 1'b0;
            end else if (in_fire) begin
                full_q  <= 1'b1;
                ready_q <= 1'b0;
            end else begin
                if (full_q && out_ready) begin
                    full_q <= 1'b0;
                end
                ready_q <= !full_q || out_ready;
            end
        end

        always_ff @(posedge aclk) begin
            if (in_fire) begin
                data_q <= in_data;
            end
        end

        assign in_ready  = ready_q;
        assign out_valid = full_q;
        assign out_data  = data_q;
    end else begin : g_full
        logic             ready_q;
        logic             out_valid_q;
        logic             skid_valid;
        logic [WIDTH-1:0] out_q;
        logic [WIDTH-1:0] skid_q;
        logic             load_out;
        logic             in_fire;

        assign in_fire  = in_valid && ready_q;
        assign load_out = out_ready || !out_valid_q;  // output register free next edge

        always_ff @(posedge aclk) begin
            if (rst) begin
                ready_q     <= 1'b0;
                out_valid_q <= 1'b0;
                skid_valid  <= 1'b0;
            end else if (load_out) begin
                out_valid_q <= skid_valid || in_fire;
                skid_valid  <= 1'b0;
                ready_q     <= 1'b1;
            end else if (in_fire) begin
                skid_valid <= 1'b1;  // output stalled, park the item
                ready_q    <= 1'b0;
            end else begin
                ready_q <= !skid_valid;
            end
        end

        always_ff @(posedge aclk) begin
            if (load_out && skid_valid) begin
                out_q <= skid_q;
            end else if (load_out && in_fire) begin
                out_q <= in_data;
            end
            if (!load_out && in_fire) begin
                skid_q <= in_data;
            end
        end

        assign in_ready  = ready_q;
        assign out_valid = out_valid_q;
        assign out_data  = out_q;
    end

endmodule

// ==== axi4l_pkg.sv ====
package axi4l_pkg;

    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;  // one bit per byte lane
    typedef logic [1:0]  resp_t;
    typedef logic [2:0]  prot_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // register stage flavour used on every channel
    typedef enum logic [1:0] {
        SLICE_BYPASS,
        SLICE_LIGHT,
        SLICE_FULL
    } slice_mode_t;

endpackage

// ==== axi4l_reg_fsm.sv ====
`timescale 1ns/1ps

module axi4l_reg_fsm (
    input  logic             aclk,
    input  logic             rst,
    input  axi4l_pkg::addr_t awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  axi4l_pkg::data_t wdata,
    input  axi4l_pkg::strb_t wstrb,
    input  logic             wvalid,
    output logic             wready,
    output axi4l_pkg::resp_t bresp,
    output logic             bvalid,
    input  logic             bready,
    input  axi4l_pkg::addr_t araddr,
    input  logic             arvalid,
    output logic             arready,
    output axi4l_pkg::data_t rdata,
    output axi4l_pkg::resp_t rresp,
    output logic             rvalid,
    input  logic             rready,
    output logic             wr_en,
    output logic             rd_en,
    output axi4l_pkg::addr_t reg_addr,
    output axi4l_pkg::data_t wr_data,
    output axi4l_pkg::strb_t wr_strb,
    input  axi4l_pkg::data_t rd_data,
    input  logic             access_err
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_t;

    state_t           state;
    axi4l_pkg::resp_t resp_q;
    axi4l_pkg::data_t rdata_q;

    // write needs address and data together, reads wait while either is pending
    assign wr_en   = (state == IDLE) && awvalid && wvalid;
    assign rd_en   = (state == IDLE) && arvalid && !awvalid && !wvalid;
    assign awready = wr_en;
    assign wready  = wr_en;
    assign arready = rd_en;

    assign reg_addr = wr_en ? awaddr : araddr;
    assign wr_data  = wdata;
    assign wr_strb  = wstrb;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_en) begin
                        state <= WRITE_RESP;
                    end else if (rd_en) begin
                        state <= READ_RESP;
                    end
                end
                WRITE_RESP: if (bready) state <= IDLE;
                READ_RESP:  if (rready) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en || rd_en) begin
            resp_q <= access_err ? axi4l_pkg::RESP_SLVERR : axi4l_pkg::RESP_OKAY;
        end
        if (rd_en) begin
            rdata_q <= rd_data;
        end
    end

    assign bvalid = (state == WRITE_RESP);
    assign rvalid = (state == READ_RESP);
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

endmodule

// ==== axi4l_reg_slice.sv ====
`timescale 1ns/1ps

module axi4l_reg_slice #(
    parameter axi4l_pkg::slice_mode_t SLICE_MODE = axi4l_pkg::SLICE_FULL
) (
    input  logic               aclk,
    input  logic               rst,
    // controller side
    input  axi4l_pkg::addr_t   awaddr,
    input  axi4l_pkg::prot_t   awprot,
    input  logic               awvalid,
    output logic               awready,
    input  axi4l_pkg::data_t   wdata,
    input  axi4l_pkg::strb_t   wstrb,
    input  logic               wvalid,
    output logic               wready,
    output axi4l_pkg::resp_t   bresp,
    output logic               bvalid,
    input  logic               bready,
    input  axi4l_pkg::addr_t   araddr,
    input  axi4l_pkg::prot_t   arprot,
    input  logic               arvalid,
    output logic               arready,
    output axi4l_pkg::data_t   rdata,
    output axi4l_pkg::resp_t   rresp,
    output logic               rvalid,
    input  logic               rready,
    // peripheral side
    output logic               p_rst,
    output axi4l_pkg::addr_t   p_awaddr,
    output axi4l_pkg::prot_t   p_awprot,
    output logic               p_awvalid,
    input  logic               p_awready,
    output axi4l_pkg::data_t   p_wdata,
    output axi4l_pkg::strb_t   p_wstrb,
    output logic               p_wvalid,
    input  logic               p_wready,
    input  axi4l_pkg::resp_t   p_bresp,
    input  logic               p_bvalid,
    output logic               p_bready,
    output axi4l_pkg::addr_t   p_araddr,
    output axi4l_pkg::prot_t   p_arprot,
    output logic               p_arvalid,
    input  logic               p_arready,
    input  axi4l_pkg::data_t   p_rdata,
    input  axi4l_pkg::resp_t   p_rresp,
    input  logic               p_rvalid,
    output logic               p_rready
);

    function automatic int reset_stages(input axi4l_pkg::slice_mode_t mode);
        case (mode)
            axi4l_pkg::SLICE_BYPASS : return 0;
            axi4l_pkg::SLICE_LIGHT  : return 1;
            default                 : return 2;
        endcase
    endfunction

    localparam int RST_STAGES = reset_stages(SLICE_MODE);

    axi4l_chan_slice #(.SLICE_MODE(SLICE_MODE), .WIDTH(35)) u_aw_slice (
        .aclk(aclk), .rst(rst),
        .in_valid(awvalid), .in_ready(awready), .in_data({awprot, awaddr}),
        .out_valid(p_awvalid), .out_ready(p_awready), .out_data({p_awprot, p_awaddr})
    );

    axi4l_chan_slice #(.SLICE_MODE(SLICE_MODE), .WIDTH(36)) u_w_slice (
        .aclk(aclk), .rst(rst),
        .in_valid(wvalid), .in_ready(wready), .in_data({wstrb, wdata}),
        .out_valid(p_wvalid), .out_ready(p_wready), .out_data({p_wstrb, p_wdata})
    );

    // response channels run peripheral to controller
    axi4l_chan_slice #(.SLICE_MODE(SLICE_MODE), .WIDTH(2)) u_b_slice (
        .aclk(aclk), .rst(rst),
        .in_valid(p_bvalid), .in_ready(p_bready), .in_data(p_bresp),
        .out_valid(bvalid), .out_ready(bready), .out_data(bresp)
    );

    axi4l_chan_slice #(.SLICE_MODE(SLICE_MODE), .WIDTH(35)) u_ar_slice (
        .aclk(aclk), .rst(rst),
        .in_valid(arvalid), .in_ready(arready), .in_data({arprot, araddr}),
        .out_valid(p_arvalid), .out_ready(p_arready), .out_data({p_arprot, p_araddr})
    );

    axi4l_chan_slice #(.SLICE_MODE(SLICE_MODE), .WIDTH(34)) u_r_slice (
        .aclk(aclk), .rst(rst),
        .in_valid(p_rvalid), .in_ready(p_rready), .in_data({p_rresp, p_rdata}),
        .out_valid(rvalid), .out_ready(rready), .out_data({rresp, rdata})
    );

    if (RST_STAGES == 0) begin : g_rst_direct
        assign p_rst = rst;
    end else begin : g_rst_pipe
        logic [RST_STAGES-1:0] rst_pipe;

        always_ff @(posedge aclk) begin
            rst_pipe[0] <= rst;
            for (int i = 1; i < RST_STAGES; i++) begin
                rst_pipe[i] <= rst_pipe[i-1];
            end
        end

        assign p_rst = rst_pipe[RST_STAGES-1];  // peripheral leaves reset after the slices
    end

endmodule

// ==== axi4l_reg_subsys.sv ====
`timescale 1ns/1ps

module axi4l_reg_subsys #(
    parameter axi4l_pkg::slice_mode_t SLICE_MODE = axi4l_pkg::SLICE_FULL
) (
    input  logic             aclk,
    input  logic             rst,
    input  axi4l_pkg::addr_t awaddr,
    input  axi4l_pkg::prot_t awprot,
    input  logic             awvalid,
    output logic             awready,
    input  axi4l_pkg::data_t wdata,
    input  axi4l_pkg::strb_t wstrb,
    input  logic             wvalid,
    output logic             wready,
    output axi4l_pkg::resp_t bresp,
    output logic             bvalid,
    input  logic             bready,
    input  axi4l_pkg::addr_t araddr,
    input  axi4l_pkg::prot_t arprot,
    input  logic             arvalid,
    output logic             arready,
    output axi4l_pkg::data_t rdata,
    output axi4l_pkg::resp_t rresp,
    output logic             rvalid,
    input  logic             rready
);

    logic             p_rst;
    axi4l_pkg::addr_t p_awaddr;
    logic             p_awvalid;
    logic             p_awready;
    axi4l_pkg::data_t p_wdata;
    axi4l_pkg::strb_t p_wstrb;
    logic             p_wvalid;
    logic             p_wready;
    axi4l_pkg::resp_t p_bresp;
    logic             p_bvalid;
    logic             p_bready;
    axi4l_pkg::addr_t p_araddr;
    logic             p_arvalid;
    logic             p_arready;
    axi4l_pkg::data_t p_rdata;
    axi4l_pkg::resp_t p_rresp;
    logic             p_rvalid;
    logic             p_rready;

    logic             wr_en;
    logic             rd_en;
    axi4l_pkg::addr_t reg_addr;
    axi4l_pkg::data_t wr_data;
    axi4l_pkg::strb_t wr_strb;
    axi4l_pkg::data_t rd_data;
    logic             access_err;
    logic             timer_enable;
    logic             timer_clear;
    axi4l_pkg::data_t count;

    axi4l_reg_slice #(.SLICE_MODE(SLICE_MODE)) u_slice (
        .aclk(aclk), .rst(rst),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .p_rst(p_rst),
        .p_awaddr(p_awaddr), .p_awprot(), .p_awvalid(p_awvalid), .p_awready(p_awready),
        .p_wdata(p_wdata), .p_wstrb(p_wstrb), .p_wvalid(p_wvalid), .p_wready(p_wready),
        .p_bresp(p_bresp), .p_bvalid(p_bvalid), .p_bready(p_bready),
        .p_araddr(p_araddr), .p_arprot(), .p_arvalid(p_arvalid), .p_arready(p_arready),
        .p_rdata(p_rdata), .p_rresp(p_rresp), .p_rvalid(p_rvalid), .p_rready(p_rready)
    );  // prot has no meaning for this peripheral

    axi4l_reg_fsm u_fsm (
        .aclk(aclk), .rst(p_rst),
        .awaddr(p_awaddr), .awvalid(p_awvalid), .awready(p_awready),
        .wdata(p_wdata), .wstrb(p_wstrb), .wvalid(p_wvalid), .wready(p_wready),
        .bresp(p_bresp), .bvalid(p_bvalid), .bready(p_bready),
        .araddr(p_araddr), .arvalid(p_arvalid), .arready(p_arready),
        .rdata(p_rdata), .rresp(p_rresp), .rvalid(p_rvalid), .rready(p_rready),
        .wr_en(wr_en), .rd_en(rd_en), .reg_addr(reg_addr),
        .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_data(rd_data), .access_err(access_err)
    );

    reg_file u_regs (
        .aclk(aclk), .rst(p_rst),
        .wr_en(wr_en), .rd_en(rd_en), .reg_addr(reg_addr),
        .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_data(rd_data), .access_err(access_err),
        .timer_enable(timer_enable), .timer_clear(timer_clear),
        .count(count)
    );

    reg_timer u_timer (
        .aclk(aclk), .rst(p_rst),
        .enable(timer_enable), .clear(timer_clear),
        .count(count)
    );

endmodule

// ==== list.f ====
axi4l_pkg.sv
reg_map_pkg.sv
axi4l_chan_slice.sv
axi4l_reg_slice.sv
axi4l_reg_fsm.sv
reg_file.sv
reg_timer.sv
axi4l_reg_subsys.sv
tb_axi4l_reg_subsys.sv

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic             aclk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic             rd_en,
    input  axi4l_pkg::addr_t reg_addr,
    input  axi4l_pkg::data_t wr_data,
    input  axi4l_pkg::strb_t wr_strb,
    output axi4l_pkg::data_t rd_data,
    output logic             access_err,
    output logic             timer_enable,
    output logic             timer_clear,
    input  axi4l_pkg::data_t count
);

    axi4l_pkg::data_t scratch_q;
    logic             enable_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            scratch_q   <= '0;
            enable_q    <= 1'b0;
            timer_clear <= 1'b0;
        end else begin
            timer_clear <= 1'b0;
            if (wr_en && reg_addr == reg_map_pkg::REG_SCRATCH) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        scratch_q[8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
            if (wr_en && reg_addr == reg_map_pkg::REG_CTRL && wr_strb[0]) begin
                enable_q    <= wr_data[reg_map_pkg::CTRL_ENABLE_BIT];
                timer_clear <= wr_data[reg_map_pkg::CTRL_CLEAR_BIT];  // one cycle pulse
            end
        end
    end

    always_comb begin
        rd_data    = '0;
        access_err = 1'b0;
        case (reg_addr)
            reg_map_pkg::REG_ID: begin
                rd_data    = reg_map_pkg::ID_VALUE;
                access_err = wr_en;  // read only
            end
            reg_map_pkg::REG_SCRATCH: rd_data = scratch_q;
            reg_map_pkg::REG_CTRL:    rd_data[reg_map_pkg::CTRL_ENABLE_BIT] = enable_q;
            reg_map_pkg::REG_COUNT: begin
                rd_data    = count;
                access_err = wr_en;
            end
            default: access_err = wr_en || rd_en;
        endcase
    end

    assign timer_enable = enable_q;

endmodule

// ==== reg_map_pkg.sv ====
package reg_map_pkg;

    localparam axi4l_pkg::addr_t REG_ID      = 32'h0000_0000;
    localparam axi4l_pkg::addr_t REG_SCRATCH = 32'h0000_0004;
    localparam axi4l_pkg::addr_t REG_CTRL    = 32'h0000_0008;
    localparam axi4l_pkg::addr_t REG_COUNT   = 32'h0000_000C;  // read only

    localparam axi4l_pkg::data_t ID_VALUE = 32'h5253_4c43;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;  // self clearing

endpackage

// ==== reg_timer.sv ====
`timescale 1ns/1ps

module reg_timer (
    input  logic             aclk,
    input  logic             rst,
    input  logic             enable,
    input  logic             clear,
    output axi4l_pkg::data_t count
);

    always_ff @(posedge aclk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;  // clear beats enable
        end else if (enable) begin
            count <= count + 32'd1;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# one build and run per slice mode: 0 bypass, 1 light, 2 full
cd "$(dirname "$0")" || exit 1

status=0
for mode in 0 1 2; do
    obj="obj_mode$mode"
    log="sim_mode$mode.log"
    verilator --binary --timing -f list.f --top-module tb_axi4l_reg_subsys \
        -GSLICE_MODE=$mode --Mdir "$obj" -o sim
    if [ $? -ne 0 ]; then
        echo "build failed for slice mode $mode"
        exit 1
    fi
    "./$obj/sim" > "$log" 2>&1
    if [ $? -ne 0 ]; then
        echo "simulation exited with an error for slice mode $mode"
        status=1
    fi
    if grep -qx "PASS: all tests" "$log"; then
        echo "slice mode $mode passed"
    else
        echo "slice mode $mode failed, see $log"
        status=1
    fi
done
exit $status

// ==== tb_axi4l_reg_subsys.sv ====
`timescale 1ns/1ps

module tb_axi4l_reg_subsys #(
    parameter int SLICE_MODE = 2  // 0 bypass, 1 light, 2 full
);

    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_RESET = 2;

    localparam int DATA_NONE    = 0;
    localparam int DATA_EXACT   = 1;
    localparam int DATA_NONZERO = 2;  // value kept for the next entry
    localparam int DATA_SAME    = 3;

    localparam int TEST_NS  = 200;
    localparam int RESET_NS = 200;

    localparam axi4l_pkg::resp_t OKAY   = 2'b00;
    localparam axi4l_pkg::resp_t SLVERR = 2'b10;

    logic             aclk;
    logic             rst;
    axi4l_pkg::addr_t awaddr;
    axi4l_pkg::prot_t awprot;
    logic             awvalid;
    logic             awready;
    axi4l_pkg::data_t wdata;
    axi4l_pkg::strb_t wstrb;
    logic             wvalid;
    logic             wready;
    axi4l_pkg::resp_t bresp;
    logic             bvalid;
    logic             bready;
    axi4l_pkg::addr_t araddr;
    axi4l_pkg::prot_t arprot;
    logic             arvalid;
    logic             arready;
    axi4l_pkg::data_t rdata;
    axi4l_pkg::resp_t rresp;
    logic             rvalid;
    logic             rready;

    string            t_name[$];
    int               t_op[$];
    axi4l_pkg::addr_t t_addr[$];
    axi4l_pkg::data_t t_data[$];
    axi4l_pkg::strb_t t_strb[$];
    axi4l_pkg::resp_t t_resp[$];
    axi4l_pkg::data_t t_exp[$];
    int               t_kind[$];

    integer           seed = 32'h1d2e;
    int               errors = 0;
    int               passed = 0;
    int               num_tests = 0;
    int               tests_done = 0;
    axi4l_pkg::resp_t got_resp;
    axi4l_pkg::data_t got_data;
    axi4l_pkg::data_t last_count;

    axi4l_reg_subsys #(.SLICE_MODE(axi4l_pkg::slice_mode_t'(SLICE_MODE))) dut (
        .aclk(aclk), .rst(rst),
        .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    function automatic axi4l_pkg::data_t merge_lanes(input axi4l_pkg::data_t old_word,
            input axi4l_pkg::data_t new_word, input axi4l_pkg::strb_t strb);
        axi4l_pkg::data_t merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic add_test(input string name, input int op, input axi4l_pkg::addr_t addr,
            input axi4l_pkg::data_t data, input axi4l_pkg::strb_t strb,
            input axi4l_pkg::resp_t resp, input axi4l_pkg::data_t exp, input int kind);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_strb.push_back(strb);
        t_resp.push_back(resp);
        t_exp.push_back(exp);
        t_kind.push_back(kind);
    endtask

    task automatic build_table();
        axi4l_pkg::data_t scratch;
        scratch = '0;
        add_test("read_id", OP_READ, reg_map_pkg::REG_ID, '0, 4'h0, OKAY,
            32'h5253_4c43, DATA_EXACT);
        add_test("read_scratch_reset", OP_READ, reg_map_pkg::REG_SCRATCH, '0, 4'h0, OKAY,
            scratch, DATA_EXACT);
        add_test("write_scratch_full", OP_WRITE, reg_map_pkg::REG_SCRATCH, 32'haabb_ccdd, 4'hf,
            OKAY, '0, DATA_NONE);
        scratch = merge_lanes(scratch, 32'haabb_ccdd, 4'hf);
        add_test("write_scratch_lanes_0_2", OP_WRITE, reg_map_pkg::REG_SCRATCH, 32'h1122_3344,
            4'h5, OKAY, '0, DATA_NONE);
        scratch = merge_lanes(scratch, 32'h1122_3344, 4'h5);
        add_test("write_scratch_lane_3", OP_WRITE, reg_map_pkg::REG_SCRATCH, 32'h9988_7766,
            4'h8, OKAY, '0, DATA_NONE);
        scratch = merge_lanes(scratch, 32'h9988_7766, 4'h8);
        add_test("write_scratch_no_lanes", OP_WRITE, reg_map_pkg::REG_SCRATCH, 32'hffff_ffff,
            4'h0, OKAY, '0, DATA_NONE);
        scratch = merge_lanes(scratch, 32'hffff_ffff, 4'h0);
        add_test("read_scratch_merged", OP_READ, reg_map_pkg::REG_SCRATCH, '0, 4'h0, OKAY,
            scratch, DATA_EXACT);
        add_test("write_id_read_only", OP_WRITE, reg_map_pkg::REG_ID, 32'h1, 4'hf, SLVERR,
            '0, DATA_NONE);
        add_test("write_count_read_only", OP_WRITE, reg_map_pkg::REG_COUNT, 32'h1, 4'hf, SLVERR,
            '0, DATA_NONE);
        add_test("write_unmapped_10", OP_WRITE, 32'h10, 32'h1234_5678, 4'hf, SLVERR,
            '0, DATA_NONE);
        add_test("read_unmapped_10", OP_READ, 32'h10, '0, 4'h0, SLVERR, '0, DATA_EXACT);
        add_test("read_unmapped_100", OP_READ, 32'h100, '0, 4'h0, SLVERR, '0, DATA_EXACT);
        add_test("read_id_after_errors", OP_READ, reg_map_pkg::REG_ID, '0, 4'h0, OKAY,
            32'h5253_4c43, DATA_EXACT);
        add_test("ctrl_enable_first", OP_WRITE, reg_map_pkg::REG_CTRL, 32'h1, 4'hf, OKAY,
            '0, DATA_NONE);
        add_test("ctrl_clear", OP_WRITE, reg_map_pkg::REG_CTRL, 32'h2, 4'hf, OKAY,
            '0, DATA_NONE);
        add_test("count_after_clear", OP_READ, reg_map_pkg::REG_COUNT, '0, 4'h0, OKAY,
            '0, DATA_EXACT);
        add_test("ctrl_enable", OP_WRITE, reg_map_pkg::REG_CTRL, 32'h1, 4'hf, OKAY,
            '0, DATA_NONE);
        add_test("read_ctrl_enabled", OP_READ, reg_map_pkg::REG_CTRL, '0, 4'h0, OKAY,
            32'h1, DATA_EXACT);
        add_test("ctrl_disable", OP_WRITE, reg_map_pkg::REG_CTRL, 32'h0, 4'hf, OKAY,
            '0, DATA_NONE);
        add_test("count_frozen_first", OP_READ, reg_map_pkg::REG_COUNT, '0, 4'h0, OKAY,
            '0, DATA_NONZERO);
        add_test("count_frozen_second", OP_READ, reg_map_pkg::REG_COUNT, '0, 4'h0, OKAY,
            '0, DATA_SAME);
        add_test("ctrl_enable_and_clear", OP_WRITE, reg_map_pkg::REG_CTRL, 32'h3, 4'hf, OKAY,
            '0, DATA_NONE);
        add_test("read_ctrl_clear_bit_low", OP_READ, reg_map_pkg::REG_CTRL, '0, 4'h0, OKAY,
            32'h1, DATA_EXACT);
        add_test("reset_mid_run", OP_RESET, '0, '0, 4'h0, OKAY, '0, DATA_NONE);
        add_test("read_scratch_after_reset", OP_READ, reg_map_pkg::REG_SCRATCH, '0, 4'h0, OKAY,
            '0, DATA_EXACT);
        add_test("read_ctrl_after_reset", OP_READ, reg_map_pkg::REG_CTRL, '0, 4'h0, OKAY,
            '0, DATA_EXACT);
    endtask

    task automatic check_resp(input string name, input axi4l_pkg::resp_t exp,
            input axi4l_pkg::resp_t act);
        if (act !== exp) begin
            $display("FAILED %s resp expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input axi4l_pkg::data_t exp,
            input axi4l_pkg::data_t act);
        if (act !== exp) begin
            $display("FAILED %s data expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_low(input string sig_name, input logic value);
        if (value !== 1'b0) begin
            $display("ERROR: %s is not low right after reset", sig_name);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (2) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        check_low("awready", awready);
        check_low("wready", wready);
        check_low("arready", arready);
        check_low("bvalid", bvalid);
        check_low("rvalid", rvalid);
        repeat (3) @(posedge aclk);  // peripheral reset trails by up to 2 stages
    endtask

    task automatic do_write(input int idx);
        bit aw_done;
        bit w_done;
        bit seen;
        bit done;
        int hold;
        int waited;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  <= t_addr[idx];
        awvalid <= 1'b1;
        wdata   <= t_data[idx];
        wstrb   <= t_strb[idx];
        wvalid  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge aclk);
            if (awvalid && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        hold   = $unsigned($random(seed)) % 5;  // bready back-pressure
        seen   = 1'b0;
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(posedge aclk);
            if (bvalid) begin
                if (!seen) begin
                    seen = 1'b1;
                    got_resp = bresp;
                end else if (bresp !== got_resp) begin
                    $display("ERROR: %s bresp changed while waiting for bready", t_name[idx]);
                    errors++;
                end
                if (bready) begin
                    done = 1'b1;
                    bready <= 1'b0;
                end else if (waited >= hold) begin
                    bready <= 1'b1;
                end
                waited++;
            end else if (seen) begin
                $display("ERROR: %s bvalid dropped before it was accepted", t_name[idx]);
                errors++;
            end
        end
    endtask

    task automatic do_read(input int idx);
        bit seen;
        bit done;
        int hold;
        int waited;
        araddr  <= t_addr[idx];
        arvalid <= 1'b1;
        done = 1'b0;
        while (!done) begin
            @(posedge aclk);
            if (arvalid && arready) begin
                done = 1'b1;
                arvalid <= 1'b0;
            end
        end
        hold   = $unsigned($random(seed)) % 5;  // rready back-pressure
        seen   = 1'b0;
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            @(posedge aclk);
            if (rvalid) begin
                if (!seen) begin
                    seen = 1'b1;
                    got_resp = rresp;
                    got_data = rdata;
                end else if (rresp !== got_resp || rdata !== got_data) begin
                    $display("ERROR: %s read response changed while waiting for rready",
                        t_name[idx]);
                    errors++;
                end
                if (rready) begin
                    done = 1'b1;
                    rready <= 1'b0;
                end else if (waited >= hold) begin
                    rready <= 1'b1;
                end
                waited++;
            end else if (seen) begin
                $display("ERROR: %s rvalid dropped before it was accepted", t_name[idx]);
                errors++;
            end
        end
    endtask

    task automatic run_entry(input int idx);
        if (t_op[idx] == OP_RESET) begin
            apply_reset();
        end else if (t_op[idx] == OP_WRITE) begin
            do_write(idx);
            check_resp(t_name[idx], t_resp[idx], got_resp);
        end else begin
            do_read(idx);
            check_resp(t_name[idx], t_resp[idx], got_resp);
            case (t_kind[idx])
                DATA_EXACT: check_data(t_name[idx], t_exp[idx], got_data);
                DATA_NONZERO: begin
                    if (got_data === '0 || $isunknown(got_data)) begin
                        $display("ERROR: %s timer did not count while enabled", t_name[idx]);
                        errors++;
                    end
                    last_count = got_data;
                end
                DATA_SAME: check_data(t_name[idx], last_count, got_data);
                default: ;
            endcase
        end
    endtask

    initial begin : main
        int errors_before;
        rst     <= 1'b1;
        awaddr  <= '0;
        awprot  <= 3'b000;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= 4'h0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arprot  <= 3'b000;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        last_count = '0;
        build_table();
        num_tests = t_name.size();
        $display("slice mode %0d, %0d tests", SLICE_MODE, num_tests);
        apply_reset();
        for (int i = 0; i < num_tests; i++) begin
            errors_before = errors;
            run_entry(i);
            tests_done++;
            if (errors == errors_before) begin
                passed++;
                $display("ok   %s", t_name[i]);
            end else begin
                $display("bad  %s", t_name[i]);
            end
        end
        $display("%0d tests run, %0d passed, %0d errors", num_tests, passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        wait (num_tests > 0);
        #(RESET_NS + num_tests * TEST_NS);
        $display("ERROR: timeout, a transaction never completed after %0d finished tests",
            tests_done);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
